//--- dii_if.sv
`timescale 1ns/1ps

interface dii_if;

   logic [15:0] data;
   logic        last;
   logic        valid;
   logic        ready;

   modport sender (
      output data, last, valid,
      input  ready
   );

   modport receiver (
      input  data, last, valid,
      output ready
   );

endinterface

//--- mam_mem.sv
`timescale 1ns/1ps

module mam_mem import mam_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  req_valid,
   output logic                  req_ready,
   input  logic                  req_rw,
   input  logic [ADDR_WIDTH-1:0] req_addr,
   input  logic [13:0]           req_beats,
   input  logic                  write_valid,
   input  logic [DATA_WIDTH-1:0] write_data,
   output logic                  write_ready,
   output logic                  read_valid,
   output logic [DATA_WIDTH-1:0] read_data,
   input  logic                  read_ready
);

   mem_state_e            state;
   logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
   logic [MEM_IDX_W-1:0]  idx;
   logic [MEM_IDX_W-1:0]  start_idx;
   logic [MEM_IDX_W-1:0]  rd_idx;
   logic [13:0]           left;  // Beats still to transfer
   logic                  req_xfer;
   logic                  rd_xfer;
   logic                  rd_load;

   assign req_ready   = (state == MEM_IDLE);
   assign write_ready = (state == MEM_WRITE);
   assign req_xfer    = req_valid && req_ready;
   assign rd_xfer     = read_valid && read_ready;

   // Byte address to beat index, wraps at depth
   assign start_idx = MEM_IDX_W'((req_addr - BASE_ADDR[ADDR_WIDTH-1:0]) >> BEAT_SHIFT);
   assign rd_load   = (req_xfer && !req_rw) || (rd_xfer && left != 14'd1);
   assign rd_idx    = req_xfer ? start_idx : idx + 1'b1;

   always_ff @(posedge clk) begin
      if (state == MEM_WRITE && write_valid) begin
         mem[idx] <= write_data;
      end
      if (rd_load) begin
         read_data <= mem[rd_idx];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= MEM_IDLE;
         read_valid <= 1'b0;
      end else begin
         case (state)
            MEM_IDLE: begin
               if (req_xfer) begin
                  idx        <= start_idx;
                  left       <= req_beats;
                  read_valid <= !req_rw;
                  state      <= req_rw ? MEM_WRITE : MEM_READ;
               end
            end
            MEM_WRITE: begin
               if (write_valid) begin
                  idx  <= idx + 1'b1;
                  left <= left - 14'd1;
                  if (left == 14'd1) begin
                     state <= MEM_IDLE;
                  end
               end
            end
            MEM_READ: begin
               if (rd_xfer) begin
                  idx  <= rd_idx;
                  left <= left - 14'd1;
                  if (left == 14'd1) begin
                     read_valid <= 1'b0;
                     state      <= MEM_IDLE;
                  end
               end
            end
            default: state <= MEM_IDLE;
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (rst) state != MEM_IDLE |-> !req_valid);

endmodule

//--- mam_pkg.sv
package mam_pkg;

   localparam int DATA_WIDTH  = 32;
   localparam int ADDR_WIDTH  = 32;
   localparam int DATA_WORDS  = DATA_WIDTH / 16;  // Flits per beat
   localparam int ADDR_WORDS  = ADDR_WIDTH / 16;  // Flits per address
   localparam int HDR_WORDS   = 3;                // Dest, src, flags
   localparam int MAX_PKT_LEN = 8;                // Including header
   localparam int MEM_WORDS   = 256;
   localparam int MEM_IDX_W   = $clog2(MEM_WORDS);
   localparam int BEAT_SHIFT  = $clog2(DATA_WIDTH / 8);

   localparam logic [63:0] BASE_ADDR   = 64'h0;
   localparam logic [63:0] MEM_SIZE    = 64'd1024;  // Bytes
   localparam logic [15:0] MOD_ID      = 16'h0003;
   localparam logic [15:0] MOD_VERSION = 16'h0000;

   // Packet type in flags bits 15:13
   typedef enum logic [2:0] {
      PKT_REG_READ,
      PKT_REG_WRITE,
      PKT_REG_RESP,
      PKT_REG_ERR,
      PKT_EVENT
   } pkt_type_e;

   typedef enum logic [15:0] {
      REG_MOD_ID      = 16'h0000,
      REG_MOD_VERSION = 16'h0001,
      REG_DATA_WIDTH  = 16'h0200,
      REG_ADDR_WIDTH  = 16'h0201,
      REG_BASE_ADDR_0 = 16'h0202,
      REG_BASE_ADDR_1 = 16'h0203,
      REG_BASE_ADDR_2 = 16'h0204,
      REG_BASE_ADDR_3 = 16'h0205,
      REG_MEM_SIZE_0  = 16'h0206,
      REG_MEM_SIZE_1  = 16'h0207,
      REG_MEM_SIZE_2  = 16'h0208,
      REG_MEM_SIZE_3  = 16'h0209
   } reg_addr_e;

   typedef enum logic [3:0] {
      MAM_IDLE,
      MAM_CMD,
      MAM_ADDR,
      MAM_REQ,
      MAM_WR_HDR,
      MAM_WR_DATA,
      MAM_WR_BEAT,
      MAM_RD_HDR,
      MAM_RD_DATA
   } mam_state_e;

   typedef enum logic [2:0] {
      RA_HDR,
      RA_REG,
      RA_RESP,
      RA_FWD_HDR,
      RA_FWD
   } ra_state_e;

   typedef enum logic [1:0] {
      MEM_IDLE,
      MEM_WRITE,
      MEM_READ
   } mem_state_e;

endpackage

//--- mam_system.f
mam_pkg.sv
dii_if.sv
osd_regaccess.sv
osd_mam.sv
mam_mem.sv
mam_system.sv
tb_mam_system.sv

//--- mam_system.sv
`timescale 1ns/1ps

module mam_system import mam_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic [15:0] id,
   input  logic [15:0] debug_in_data,
   input  logic        debug_in_last,
   input  logic        debug_in_valid,
   output logic        debug_in_ready,
   output logic [15:0] debug_out_data,
   output logic        debug_out_last,
   output logic        debug_out_valid,
   input  logic        debug_out_ready
);

   dii_if debug_in ();
   dii_if debug_out ();

   logic                  req_valid;
   logic                  req_ready;
   logic                  req_rw;
   logic [ADDR_WIDTH-1:0] req_addr;
   logic [13:0]           req_beats;
   logic                  write_valid;
   logic [DATA_WIDTH-1:0] write_data;
   logic                  write_ready;
   logic                  read_valid;
   logic [DATA_WIDTH-1:0] read_data;
   logic                  read_ready;

   assign debug_in.data   = debug_in_data;
   assign debug_in.last   = debug_in_last;
   assign debug_in.valid  = debug_in_valid;
   assign debug_in_ready  = debug_in.ready;
   assign debug_out_data  = debug_out.data;
   assign debug_out_last  = debug_out.last;
   assign debug_out_valid = debug_out.valid;
   assign debug_out.ready = debug_out_ready;

   osd_mam u_mam (
      .clk, .rst, .id,
      .dp_in  (debug_in),
      .dp_out (debug_out),
      .req_valid, .req_ready, .req_rw, .req_addr, .req_beats,
      .write_valid, .write_data, .write_ready,
      .read_valid, .read_data, .read_ready
   );

   mam_mem u_mem (
      .clk, .rst,
      .req_valid, .req_ready, .req_rw, .req_addr, .req_beats,
      .write_valid, .write_data, .write_ready,
      .read_valid, .read_data, .read_ready
   );

endmodule

//--- osd_mam.sv
`timescale 1ns/1ps

module osd_mam import mam_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [15:0]           id,
   dii_if.receiver               dp_in,
   dii_if.sender                 dp_out,
   output logic                  req_valid,
   input  logic                  req_ready,
   output logic                  req_rw,       // 1 for write
   output logic [ADDR_WIDTH-1:0] req_addr,
   output logic [13:0]           req_beats,
   output logic                  write_valid,
   output logic [DATA_WIDTH-1:0] write_data,
   input  logic                  write_ready,
   input  logic                  read_valid,
   input  logic [DATA_WIDTH-1:0] read_data,
   output logic                  read_ready
);

   logic [15:0] reg_addr;
   logic [15:0] reg_rdata;
   logic        reg_err;

   dii_if mod_in ();
   dii_if mod_out ();

   osd_regaccess u_regaccess (
      .clk       (clk),
      .rst       (rst),
      .id        (id),
      .debug_in  (dp_in),
      .debug_out (dp_out),
      .mod_out   (mod_in),
      .mod_in    (mod_out),
      .reg_addr  (reg_addr),
      .reg_rdata (reg_rdata),
      .reg_err   (reg_err)
   );

   always_comb begin
      reg_err   = 1'b0;
      reg_rdata = 16'h0;
      case (reg_addr)
         REG_DATA_WIDTH:  reg_rdata = 16'(DATA_WIDTH);
         REG_ADDR_WIDTH:  reg_rdata = 16'(ADDR_WIDTH);
         REG_BASE_ADDR_0: reg_rdata = BASE_ADDR[15:0];
         REG_BASE_ADDR_1: reg_rdata = BASE_ADDR[31:16];
         REG_BASE_ADDR_2: reg_rdata = BASE_ADDR[47:32];
         REG_BASE_ADDR_3: reg_rdata = BASE_ADDR[63:48];
         REG_MEM_SIZE_0:  reg_rdata = MEM_SIZE[15:0];
         REG_MEM_SIZE_1:  reg_rdata = MEM_SIZE[31:16];
         REG_MEM_SIZE_2:  reg_rdata = MEM_SIZE[47:32];
         REG_MEM_SIZE_3:  reg_rdata = MEM_SIZE[63:48];
         default:         reg_err = 1'b1;
      endcase
   end

   mam_state_e                      state;
   logic [$clog2(MAX_PKT_LEN+1)-1:0] cnt;   // Header, address or packet words
   logic [$clog2(DATA_WORDS)-1:0]    wcnt;  // Flit within beat
   logic                             in_packet;
   logic [15:0]                      src_q;
   logic [DATA_WIDTH-1:0]            rd_buf;
   logic                             rd_full;
   logic [15:0]                      hdr_word;
   logic                             pkt_end;

   assign mod_in.ready = state inside {MAM_IDLE, MAM_CMD, MAM_ADDR, MAM_WR_HDR, MAM_WR_DATA};
   assign req_valid    = (state == MAM_REQ);
   assign write_valid  = (state == MAM_WR_BEAT);
   assign read_ready   = (state == MAM_RD_HDR || state == MAM_RD_DATA) && !rd_full;

   // Close the packet on the final beat or when another beat will not fit
   assign pkt_end = (wcnt == DATA_WORDS - 1) &&
                    ((req_beats == 14'd1) || (cnt + 1 + DATA_WORDS > MAX_PKT_LEN));

   assign hdr_word = (cnt == 0) ? src_q :
                     (cnt == 1) ? id : {PKT_EVENT, 13'h0};

   assign mod_out.valid = (state == MAM_RD_HDR) || (state == MAM_RD_DATA && rd_full);
   assign mod_out.data  = (state == MAM_RD_HDR) ? hdr_word :
                          rd_buf[(DATA_WORDS - 1 - wcnt) * 16 +: 16];  // High half first
   assign mod_out.last  = (state == MAM_RD_DATA) && pkt_end;

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= MAM_IDLE;
         cnt       <= '0;
         wcnt      <= '0;
         in_packet <= 1'b0;
         rd_full   <= 1'b0;
      end else begin
         if (read_valid && read_ready) begin
            rd_buf  <= read_data;
            rd_full <= 1'b1;
         end
         case (state)
            MAM_IDLE: begin
               if (mod_in.valid) begin
                  cnt <= cnt + 1'b1;
                  if (cnt == 1) begin
                     src_q <= mod_in.data;  // Reply destination
                  end
                  if (cnt == HDR_WORDS - 1) begin
                     cnt   <= '0;
                     state <= MAM_CMD;
                  end
               end
            end
            MAM_CMD: begin
               if (mod_in.valid) begin
                  req_rw    <= mod_in.data[15];
                  req_beats <= mod_in.data[13:0];  // Burst bit implied by count
                  state     <= MAM_ADDR;
               end
            end
            MAM_ADDR: begin
               if (mod_in.valid) begin
                  req_addr[(ADDR_WORDS - 1 - cnt) * 16 +: 16] <= mod_in.data;
                  cnt <= cnt + 1'b1;
                  if (cnt == ADDR_WORDS - 1) begin
                     cnt   <= '0;
                     state <= MAM_REQ;
                  end
               end
            end
            MAM_REQ: begin
               if (req_ready) begin
                  in_packet <= 1'b0;
                  state     <= req_rw ? MAM_WR_HDR : MAM_RD_HDR;
               end
            end
            MAM_WR_HDR: begin
               if (mod_in.valid) begin
                  cnt <= cnt + 1'b1;
                  if (cnt == HDR_WORDS - 1) begin
                     cnt   <= '0;
                     state <= MAM_WR_DATA;
                  end
               end
            end
            MAM_WR_DATA: begin
               if (mod_in.valid) begin
                  write_data[(DATA_WORDS - 1 - wcnt) * 16 +: 16] <= mod_in.data;
                  wcnt <= wcnt + 1'b1;
                  if (wcnt == DATA_WORDS - 1) begin
                     wcnt      <= '0;
                     in_packet <= !mod_in.last;
                     state     <= MAM_WR_BEAT;
                  end
               end
            end
            MAM_WR_BEAT: begin
               if (write_ready) begin
                  req_beats <= req_beats - 14'd1;
                  if (req_beats == 14'd1) begin
                     state <= MAM_IDLE;
                  end else begin
                     state <= in_packet ? MAM_WR_DATA : MAM_WR_HDR;
                  end
               end
            end
            MAM_RD_HDR: begin
               if (mod_out.ready) begin
                  cnt <= cnt + 1'b1;
                  if (cnt == HDR_WORDS - 1) begin
                     state <= MAM_RD_DATA;
                  end
               end
            end
            MAM_RD_DATA: begin
               if (mod_out.valid && mod_out.ready) begin
                  cnt  <= cnt + 1'b1;
                  wcnt <= wcnt + 1'b1;
                  if (wcnt == DATA_WORDS - 1) begin
                     wcnt      <= '0;
                     rd_full   <= 1'b0;
                     req_beats <= req_beats - 14'd1;
                     if (req_beats == 14'd1) begin
                        cnt   <= '0;
                        state <= MAM_IDLE;
                     end else if (pkt_end) begin
                        cnt   <= '0;
                        state <= MAM_RD_HDR;
                     end
                  end
               end
            end
            default: state <= MAM_IDLE;
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (rst) req_valid |-> req_beats != 14'd0);

endmodule

//--- osd_regaccess.sv
`timescale 1ns/1ps

module osd_regaccess import mam_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic [15:0] id,
   dii_if.receiver     debug_in,
   dii_if.sender       debug_out,
   dii_if.sender       mod_out,
   dii_if.receiver     mod_in,
   output logic [15:0] reg_addr,
   input  logic [15:0] reg_rdata,
   input  logic        reg_err
);

   ra_state_e   state;
   logic [15:0] hdr [HDR_WORDS];
   logic [1:0]  cnt;
   logic [15:0] addr_q;
   logic        is_write;
   pkt_type_e   in_type;

   logic [15:0] reg_val;
   logic        resp_err;
   pkt_type_e   resp_type;
   logic [15:0] resp_data;
   logic        resp_last;
   logic        resp_valid;

   logic        sel_mod;
   logic        sel_q;
   logic        lock;
   logic        out_xfer;

   assign in_type  = pkt_type_e'(debug_in.data[15:13]);
   assign reg_addr = addr_q;

   assign debug_in.ready = (state == RA_HDR) || (state == RA_REG) ||
                           (state == RA_FWD && mod_out.ready);

   // Header replay, then straight pass-through
   assign mod_out.valid = (state == RA_FWD_HDR) || (state == RA_FWD && debug_in.valid);
   assign mod_out.data  = (state == RA_FWD_HDR) ? hdr[cnt] : debug_in.data;
   assign mod_out.last  = (state == RA_FWD) && debug_in.last;

   always_comb begin
      resp_err = is_write;
      reg_val  = reg_rdata;
      case (addr_q)
         REG_MOD_ID:      reg_val = MOD_ID;
         REG_MOD_VERSION: reg_val = MOD_VERSION;
         default:         resp_err = is_write || reg_err;
      endcase
      resp_type = resp_err ? PKT_REG_ERR : PKT_REG_RESP;
      case (cnt)
         2'd0:    resp_data = hdr[1];  // Back to requester
         2'd1:    resp_data = id;
         2'd2:    resp_data = {resp_type, 13'h0};
         default: resp_data = reg_val;
      endcase
      resp_last = (cnt == 2'd3) || (resp_err && cnt == 2'd2);
   end

   assign resp_valid = (state == RA_RESP);

   // Packet-level merge, responses first
   assign sel_mod         = lock ? sel_q : !resp_valid;
   assign debug_out.valid = sel_mod ? mod_in.valid : resp_valid;
   assign debug_out.data  = sel_mod ? mod_in.data : resp_data;
   assign debug_out.last  = sel_mod ? mod_in.last : resp_last;
   assign mod_in.ready    = sel_mod && debug_out.ready;
   assign out_xfer        = debug_out.valid && debug_out.ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         lock  <= 1'b0;
         sel_q <= 1'b0;
      end else begin
         if (!lock) begin
            sel_q <= sel_mod;
         end
         if (out_xfer && debug_out.last) begin
            lock <= 1'b0;
         end else if (debug_out.valid) begin
            lock <= 1'b1;  // Hold source once a word is offered
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= RA_HDR;
         cnt   <= 2'd0;
      end else begin
         case (state)
            RA_HDR: begin
               if (debug_in.valid) begin
                  hdr[cnt] <= debug_in.data;
                  cnt      <= cnt + 2'd1;
                  if (cnt == 2'(HDR_WORDS - 1)) begin
                     cnt <= 2'd0;
                     if (in_type == PKT_REG_READ || in_type == PKT_REG_WRITE) begin
                        is_write <= (in_type == PKT_REG_WRITE);
                        state    <= RA_REG;
                     end else begin
                        state <= RA_FWD_HDR;
                     end
                  end
               end
            end
            RA_REG: begin
               if (debug_in.valid) begin
                  if (cnt == 2'd0) begin
                     addr_q <= debug_in.data;  // First payload word
                  end
                  cnt <= 2'd1;
                  if (debug_in.last) begin
                     cnt   <= 2'd0;
                     state <= RA_RESP;
                  end
               end
            end
            RA_RESP: begin
               if (out_xfer && !sel_mod) begin
                  cnt <= cnt + 2'd1;
                  if (resp_last) begin
                     cnt   <= 2'd0;
                     state <= RA_HDR;
                  end
               end
            end
            RA_FWD_HDR: begin
               if (mod_out.ready) begin
                  cnt <= cnt + 2'd1;
                  if (cnt == 2'(HDR_WORDS - 1)) begin
                     cnt   <= 2'd0;
                     state <= RA_FWD;
                  end
               end
            end
            RA_FWD: begin
               if (debug_in.valid && mod_out.ready && debug_in.last) begin
                  state <= RA_HDR;
               end
            end
            default: state <= RA_HDR;
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (rst)
      debug_out.valid && !debug_out.ready |=> debug_out.valid && $stable(debug_out.data));

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_mam_system -f mam_system.f -o sim_mam_system

./obj_dir/sim_mam_system > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
exit 0

//--- tb_mam_system.sv
`timescale 1ns/1ps

module tb_mam_system import mam_pkg::*; ();

   localparam logic [15:0] DUT_ID  = 16'h0005;
   localparam logic [15:0] TB_SRC  = 16'h0001;
   localparam int          MAX_WAIT = 4000;  // Cycles per packet wait

   logic        clk;
   logic        rst;
   logic [15:0] debug_in_data;
   logic        debug_in_last;
   logic        debug_in_valid;
   logic        debug_in_ready;
   logic [15:0] debug_out_data;
   logic        debug_out_last;
   logic        debug_out_valid;
   logic        debug_out_ready;

   logic        back_pressure;
   int          errors;
   int          test_errors;
   int          tests_pass;
   int          tests_fail;
   int          cur_len;
   int unsigned seed_val;

   logic [15:0] rx_words [$];
   int          rx_lens  [$];
   logic [15:0] cur_pkt  [$];
   logic [15:0] exp_q    [$];
   logic [15:0] tx_q     [$];
   logic [31:0] model    [MEM_WORDS];

   mam_system mam_system_i (
      .clk, .rst, .id (DUT_ID),
      .debug_in_data, .debug_in_last, .debug_in_valid, .debug_in_ready,
      .debug_out_data, .debug_out_last, .debug_out_valid, .debug_out_ready
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #200us;
      $display("Timeout: the run did not finish within 200 us");
      $display("Simulation failed");
      $finish;
   end

   assert property (@(posedge clk) disable iff (rst)
      debug_out_valid && !debug_out_ready |=>
         debug_out_valid && $stable(debug_out_data) && $stable(debug_out_last))
   else begin
      $display("debug_out changed while stalled at %0t", $time);
      errors++;
   end

   assert property (@(posedge clk) rst |=> !debug_out_valid)
   else begin
      $display("debug_out_valid high during reset at %0t", $time);
      errors++;
   end

   // Random stall of the output stream
   always @(negedge clk) begin
      debug_out_ready <= back_pressure ? (($urandom % 3) != 0) : 1'b1;
   end

   // Collect packets as they leave the DUT
   always @(posedge clk) begin
      if (!rst && debug_out_valid && debug_out_ready) begin
         rx_words.push_back(debug_out_data);
         cur_len++;
         if (debug_out_last) begin
            rx_lens.push_back(cur_len);
            cur_len = 0;
         end
      end
   end

   task automatic send_packet();
      int i;
      for (i = 0; i < tx_q.size(); i++) begin
         debug_in_data  = tx_q[i];
         debug_in_last  = (i == tx_q.size() - 1);
         debug_in_valid = 1'b1;
         while (!debug_in_ready) begin
            @(negedge clk);
         end
         @(negedge clk);
      end
      debug_in_valid = 1'b0;
      debug_in_last  = 1'b0;
   endtask

   task automatic reg_request(input logic write, input logic [15:0] addr);
      tx_q.delete();
      tx_q.push_back(DUT_ID);
      tx_q.push_back(TB_SRC);
      tx_q.push_back({write ? PKT_REG_WRITE : PKT_REG_READ, 13'h0});
      tx_q.push_back(addr);
      if (write) begin
         tx_q.push_back(16'h1234);
      end
      send_packet();
   endtask

   task automatic mem_command(input logic write, input int beats, input logic [31:0] addr);
      tx_q.delete();
      tx_q.push_back(DUT_ID);
      tx_q.push_back(TB_SRC);
      tx_q.push_back({PKT_EVENT, 13'h0});
      tx_q.push_back({write, beats > 1, 14'(beats)});
      tx_q.push_back(addr[31:16]);
      tx_q.push_back(addr[15:0]);
      send_packet();
   endtask

   // One data packet of random beats, mirrored into the model
   task automatic write_data_pkt(input int first_beat, input int count);
      int          b;
      logic [31:0] val;
      tx_q.delete();
      tx_q.push_back(DUT_ID);
      tx_q.push_back(TB_SRC);
      tx_q.push_back({PKT_EVENT, 13'h0});
      for (b = 0; b < count; b++) begin
         val = $urandom;
         model[(first_beat + b) % MEM_WORDS] = val;
         tx_q.push_back(val[31:16]);
         tx_q.push_back(val[15:0]);
      end
      send_packet();
   endtask

   task automatic wait_packets(input int n);
      int cycles;
      cycles = 0;
      while (rx_lens.size() < n && cycles < MAX_WAIT * n) begin
         @(negedge clk);
         cycles++;
      end
      if (rx_lens.size() < n) begin
         $display("No response: expected %0d packets but got %0d", n, rx_lens.size());
         errors++;
      end
   endtask

   task automatic pop_packet();
      int len;
      int i;
      cur_pkt.delete();
      if (rx_lens.size() != 0) begin
         len = rx_lens.pop_front();
         for (i = 0; i < len; i++) begin
            cur_pkt.push_back(rx_words.pop_front());
         end
      end
   endtask

   task automatic compare_packet(input string what);
      int i;
      if (cur_pkt.size() != exp_q.size()) begin
         $display("mismatch at %0t: %s packet length got %0d expected %0d",
                  $time, what, cur_pkt.size(), exp_q.size());
         errors++;
      end else begin
         for (i = 0; i < exp_q.size(); i++) begin
            assert (cur_pkt[i] === exp_q[i])
            else begin
               $display("mismatch at %0t: debug_out_data (%s word %0d) got %h expected %h",
                        $time, what, i, cur_pkt[i], exp_q[i]);
               errors++;
            end
         end
      end
   endtask

   task automatic expect_reg(input logic is_err, input logic [15:0] value);
      exp_q.delete();
      exp_q.push_back(TB_SRC);
      exp_q.push_back(DUT_ID);
      exp_q.push_back({is_err ? PKT_REG_ERR : PKT_REG_RESP, 13'h0});
      if (!is_err) begin
         exp_q.push_back(value);
      end
   endtask

   task automatic expect_read(input int first_beat, input int count);
      int b;
      exp_q.delete();
      exp_q.push_back(TB_SRC);
      exp_q.push_back(DUT_ID);
      exp_q.push_back({PKT_EVENT, 13'h0});
      for (b = 0; b < count; b++) begin
         exp_q.push_back(model[(first_beat + b) % MEM_WORDS][31:16]);  // High half first
         exp_q.push_back(model[(first_beat + b) % MEM_WORDS][15:0]);
      end
   endtask

   task automatic check_reg(input logic [15:0] addr, input logic is_err,
                            input logic [15:0] value, input string what);
      reg_request(1'b0, addr);
      wait_packets(1);
      pop_packet();
      expect_reg(is_err, value);
      compare_packet(what);
   endtask

   // Read packets hold as many whole beats as fit
   task automatic check_read(input int first_beat, input int nbeats);
      int bpp;
      int b;
      int n;
      bpp = (MAX_PKT_LEN - HDR_WORDS) / DATA_WORDS;
      wait_packets((nbeats + bpp - 1) / bpp);
      b = 0;
      while (b < nbeats) begin
         n = (nbeats - b < bpp) ? nbeats - b : bpp;
         pop_packet();
         expect_read(first_beat + b, n);
         compare_packet("read data");
         b += n;
      end
   endtask

   task automatic begin_test();
      test_errors = errors;
   endtask

   task automatic end_test(input string name);
      if (errors == test_errors) begin
         $display("test %s: passed", name);
         tests_pass++;
      end else begin
         $display("test %s: failed", name);
         tests_fail++;
      end
   endtask

   initial begin
      int bpp;
      int k;
      int resp_seen;
      seed_val        = $urandom(78522);
      rst             = 1'b1;
      debug_in_data   = 16'h0;
      debug_in_last   = 1'b0;
      debug_in_valid  = 1'b0;
      debug_out_ready = 1'b1;
      back_pressure   = 1'b0;
      errors          = 0;
      tests_pass      = 0;
      tests_fail      = 0;
      cur_len         = 0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      begin_test();
      assert (debug_out_valid === 1'b0)
      else begin
         $display("mismatch at %0t: debug_out_valid got %b expected 0", $time, debug_out_valid);
         errors++;
      end
      assert (debug_in_ready === 1'b1)
      else begin
         $display("mismatch at %0t: debug_in_ready got %b expected 1", $time, debug_in_ready);
         errors++;
      end
      end_test("reset state");

      begin_test();
      check_reg(REG_MOD_ID, 1'b0, MOD_ID, "mod id");
      check_reg(REG_DATA_WIDTH, 1'b0, 16'd32, "data width");
      check_reg(REG_MEM_SIZE_0, 1'b0, 16'd1024, "mem size");
      end_test("register reads");

      begin_test();
      check_reg(16'h0100, 1'b1, 16'h0, "unmapped read");
      reg_request(1'b1, REG_MOD_ID);
      wait_packets(1);
      pop_packet();
      expect_reg(1'b1, 16'h0);
      compare_packet("register write");
      end_test("register errors");

      begin_test();
      mem_command(1'b1, 1, 32'h0000_0010);
      write_data_pkt(4, 1);
      mem_command(1'b0, 1, 32'h0000_0010);
      check_read(4, 1);
      end_test("single beat");

      begin_test();
      mem_command(1'b1, 8, 32'h0000_0040);
      write_data_pkt(16, 3);
      write_data_pkt(19, 3);
      write_data_pkt(22, 2);
      back_pressure = 1'b1;
      mem_command(1'b0, 8, 32'h0000_0040);
      check_read(16, 8);
      back_pressure = 1'b0;
      end_test("burst");

      begin_test();
      back_pressure = 1'b1;
      bpp = (MAX_PKT_LEN - HDR_WORDS) / DATA_WORDS;
      mem_command(1'b0, 8, 32'h0000_0040);
      reg_request(1'b0, REG_DATA_WIDTH);
      wait_packets(8 / bpp + 1);
      k         = 0;
      resp_seen = 0;
      repeat (8 / bpp + 1) begin
         pop_packet();
         if (cur_pkt.size() >= 3 && cur_pkt[2] == {PKT_REG_RESP, 13'h0}) begin
            expect_reg(1'b0, 16'd32);
            compare_packet("interleaved response");
            resp_seen++;
         end else begin
            expect_read(16 + k * bpp, bpp);
            compare_packet("interleaved read");
            k++;
         end
      end
      if (resp_seen != 1) begin
         $display("Register response seen %0d times during the read burst", resp_seen);
         errors++;
      end
      back_pressure = 1'b0;
      end_test("interleave");

      $display("tests passed %0d failed %0d", tests_pass, tests_fail);
      if (errors == 0 && tests_fail == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
